//--- sim.f
src/ll_sync_pkg.sv
src/ll_apb_pkg.sv
src/level_delay.sv
src/ll_auto_sync.sv
src/ll_sync_regs.sv
src/ll_sync_top.sv
sim/ll_sync_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= ll_sync_tb
RTL_TOP   ?= ll_sync_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/ll_sync_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ll_sync_tb import ll_sync_pkg::*, ll_apb_pkg::*; ();

  logic                      clk_wr;
  logic                      rst_wr_n;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic [MARKER_WIDTH-1:0]   tx_mrk_userbit;
  logic                      tx_stb_userbit;
  logic [MARKER_WIDTH-1:0]   tx_auto_mrk_userbit;
  logic                      tx_auto_stb_userbit;
  logic                      tx_online_delay;
  logic                      rx_online_delay;
  int                        errors;
  int                        checks;

  ll_sync_top ll_sync_top_i (.*);

  // 10 ns clock
  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic actual, input logic expected);
    checks++;
    assert (actual === expected) else begin
      $display("ERROR at %0t ns: %s expected %0b, got %0b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [APB_DATA_WIDTH-1:0] actual,
                            input logic [APB_DATA_WIDTH-1:0] expected);
    checks++;
    assert (actual === expected) else begin
      $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Setup phase, access phase, then bus idle again one half cycle after the access edge
  task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                           input logic [APB_DATA_WIDTH-1:0] data, input logic exp_err);
    @(negedge clk_wr);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_wr);
    penable = 1'b1;
    #1;
    check_bit("pready", pready, 1'b1);
    check_bit("pslverr", pslverr, exp_err);
    @(negedge clk_wr);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr, input logic exp_err,
                          output logic [APB_DATA_WIDTH-1:0] data);
    @(negedge clk_wr);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk_wr);
    penable = 1'b1;
    #1;
    check_bit("pready", pready, 1'b1);
    check_bit("pslverr", pslverr, exp_err);
    // prdata is only valid in the access phase
    data = prdata;
    @(negedge clk_wr);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_expect(input logic [APB_ADDR_WIDTH-1:0] addr, input logic exp_err,
                             input logic [APB_DATA_WIDTH-1:0] exp_data, input string name);
    logic [APB_DATA_WIDTH-1:0] data;
    apb_read(addr, exp_err, data);
    check_word(name, data, exp_data);
  endtask

  // One cycle of user bits, outputs checked after they settle
  task automatic user_cycle(input logic [MARKER_WIDTH-1:0] mrk, input logic stb,
                            input logic [MARKER_WIDTH-1:0] exp_mrk, input logic exp_stb);
    @(negedge clk_wr);
    tx_mrk_userbit = mrk;
    tx_stb_userbit = stb;
    #1;
    check_word("tx_auto_mrk_userbit", 32'(tx_auto_mrk_userbit), 32'(exp_mrk));
    check_bit("tx_auto_stb_userbit", tx_auto_stb_userbit, exp_stb);
  endtask

  function automatic logic [MARKER_WIDTH-1:0] rand_marker();
    return MARKER_WIDTH'($urandom_range((1 << MARKER_WIDTH) - 1, 1));
  endfunction

  // Polls an online output once per cycle, gives up after limit cycles
  task automatic wait_level(input logic sel_rx, input logic level, input int limit);
    int n;
    n = 0;
    while (((sel_rx ? rx_online_delay : tx_online_delay) !== level) && (n < limit)) begin
      @(negedge clk_wr);
      n++;
    end
    checks++;
    assert ((sel_rx ? rx_online_delay : tx_online_delay) === level) else begin
      $display("Timed out after %0d cycles waiting for %s to go %0b", limit,
               sel_rx ? "rx_online_delay" : "tx_online_delay", level);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_register_access();
    logic [DELAY_WIDTH-1:0] xz;
    logic [DELAY_WIDTH-1:0] yz;
    logic [DELAY_WIDTH-1:0] x;
    xz = DELAY_WIDTH'($urandom_range(255, 1));
    yz = DELAY_WIDTH'($urandom_range(255, 1));
    x  = DELAY_WIDTH'($urandom_range(255, 1));
    // Everything clears on reset
    read_expect(CTRL, 1'b0, '0, "CTRL after reset");
    read_expect(DELAY_XZ, 1'b0, '0, "DELAY_XZ after reset");
    read_expect(DELAY_YZ, 1'b0, '0, "DELAY_YZ after reset");
    read_expect(DELAY_X, 1'b0, '0, "DELAY_X after reset");
    read_expect(STATUS, 1'b0, '0, "STATUS after reset");
    apb_write(DELAY_XZ, 32'(xz), 1'b0);
    apb_write(DELAY_YZ, 32'(yz), 1'b0);
    apb_write(DELAY_X, 32'(x), 1'b0);
    read_expect(DELAY_XZ, 1'b0, 32'(xz), "DELAY_XZ readback");
    read_expect(DELAY_YZ, 1'b0, 32'(yz), "DELAY_YZ readback");
    read_expect(DELAY_X, 1'b0, 32'(x), "DELAY_X readback");
    // Outside the map
    apb_write(8'h14, 32'hffff_ffff, 1'b1);
    read_expect(8'h14, 1'b1, '0, "prdata at 0x14");
    read_expect(8'hfc, 1'b1, '0, "prdata at 0xfc");
    // STATUS is read only
    apb_write(STATUS, 32'h7, 1'b1);
    read_expect(STATUS, 1'b0, '0, "STATUS after write");
    read_expect(CTRL, 1'b0, '0, "CTRL after bad writes");
  endtask

  task automatic test_markers_before_lock();
    logic [MARKER_WIDTH-1:0] m;
    repeat (6) begin
      m = rand_marker();
      user_cycle(m, 1'b1, m, 1'b0);
    end
    user_cycle('0, 1'b1, '0, 1'b0);
  endtask

  task automatic test_tx_bringup();
    int                        xz;
    int                        yz;
    int                        total;
    int                        k;
    logic [APB_DATA_WIDTH-1:0] data;
    xz    = $urandom_range(20, 0);
    yz    = $urandom_range(20, 0);
    total = xz + yz + 2;
    $display("TX bring-up, X+Z %0d, Y+Z %0d", xz, yz);
    apb_write(DELAY_XZ, 32'(xz), 1'b0);
    apb_write(DELAY_YZ, 32'(yz), 1'b0);
    apb_write(CTRL, 32'h1, 1'b0);
    // k counts edges since the CTRL access edge
    for (k = 0; k <= total + 3; k++) begin
      if (k > 0) begin
        @(negedge clk_wr);
      end
      check_bit("tx_online_delay", tx_online_delay, k >= total);
      // No marker yet so the strobe window is shut
      check_bit("tx_auto_stb_userbit", tx_auto_stb_userbit, 1'b0);
    end
    apb_read(STATUS, 1'b0, data);
    check_bit("STATUS tx lock", data[STAT_TX_LOCK_BIT], 1'b1);
    check_bit("STATUS tx online", data[STAT_TX_ONLINE_BIT], 1'b1);
  endtask

  task automatic test_rx_bringup();
    int                        x;
    int                        k;
    logic [APB_DATA_WIDTH-1:0] data;
    x = $urandom_range(20, 0);
    $display("RX bring-up, X %0d", x);
    apb_write(DELAY_X, 32'(x), 1'b0);
    // TX request stays on
    apb_write(CTRL, 32'h3, 1'b0);
    for (k = 0; k <= x + 4; k++) begin
      if (k > 0) begin
        @(negedge clk_wr);
      end
      check_bit("rx_online_delay", rx_online_delay, k >= x + 1);
      check_bit("tx_online_delay", tx_online_delay, 1'b1);
    end
    apb_read(STATUS, 1'b0, data);
    check_bit("STATUS rx online", data[STAT_RX_ONLINE_BIT], 1'b1);
  endtask

  // Lock is up and no marker has been seen, strobe held high throughout
  task automatic test_marker_strobe();
    logic [MARKER_WIDTH-1:0] m;
    int                      gap;
    gap = $urandom_range(4, 1);
    repeat (gap) begin
      user_cycle('0, 1'b1, '0, 1'b0);
    end
    // First marker goes out, window opens one cycle later
    m = rand_marker();
    user_cycle(m, 1'b1, m, 1'b0);
    gap = $urandom_range(4, 1);
    repeat (gap) begin
      user_cycle('0, 1'b1, '0, 1'b1);
    end
    // Second marker is blocked but its cycle is still in the window
    m = rand_marker();
    user_cycle(m, 1'b1, '0, 1'b1);
    repeat (5) begin
      m = rand_marker();
      user_cycle(m, 1'b1, '0, 1'b0);
    end
    user_cycle('0, 1'b1, '0, 1'b0);
  endtask

  task automatic test_drop_rearm();
    logic [MARKER_WIDTH-1:0] m;
    apb_write(CTRL, 32'h0, 1'b0);
    // RX has one stage, TX has two
    wait_level(1'b1, 1'b0, 1);
    wait_level(1'b0, 1'b0, 1);
    repeat (4) begin
      m = rand_marker();
      user_cycle(m, 1'b1, m, 1'b0);
    end
    user_cycle('0, 1'b1, '0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    errors = 0;
    checks = 0;
    void'($urandom(32'ha783b49a));
    rst_wr_n       = 1'b0;
    paddr          = '0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    pwdata         = '0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = 1'b0;
    repeat (4) @(posedge clk_wr);
    @(negedge clk_wr);
    rst_wr_n = 1'b1;

    test_register_access();
    test_markers_before_lock();
    test_tx_bringup();
    test_rx_bringup();
    test_marker_strobe();
    test_drop_rearm();
    // Second bring-up with fresh delays
    test_tx_bringup();
    test_marker_strobe();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/ll_sync_top.sv
`timescale 1ns/1ps
`default_nettype none

// Link bring-up sequencer with its APB register block
module ll_sync_top import ll_sync_pkg::*, ll_apb_pkg::*; (
  input  logic                      clk_wr,
  input  logic                      rst_wr_n,

  // APB slave
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,

  // User bits in and gated out
  input  logic [MARKER_WIDTH-1:0]   tx_mrk_userbit,
  input  logic                      tx_stb_userbit,
  output logic [MARKER_WIDTH-1:0]   tx_auto_mrk_userbit,
  output logic                      tx_auto_stb_userbit,

  // Delayed online indications
  output logic                      tx_online_delay,
  output logic                      rx_online_delay
);

  logic                   tx_online;
  logic                   rx_online;
  logic                   tx_lock;
  logic [DELAY_WIDTH-1:0] delay_xz_value;
  logic [DELAY_WIDTH-1:0] delay_yz_value;
  logic [DELAY_WIDTH-1:0] delay_x_value;

  ll_sync_regs ll_sync_regs_i (.*);

  ll_auto_sync ll_auto_sync_i (.*);

endmodule

`default_nettype wire

//--- src/ll_sync_regs.sv
`timescale 1ns/1ps
`default_nettype none

// APB register block of the link sequencer
// Zero wait states, errors on unmapped addresses and STATUS writes
module ll_sync_regs import ll_sync_pkg::*, ll_apb_pkg::*; (
  input  logic                      clk_wr,
  input  logic                      rst_wr_n,

  // APB slave
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,

  // Control towards the sequencer
  output logic                      tx_online,
  output logic                      rx_online,
  output logic [DELAY_WIDTH-1:0]    delay_xz_value,
  output logic [DELAY_WIDTH-1:0]    delay_yz_value,
  output logic [DELAY_WIDTH-1:0]    delay_x_value,

  // Live status from the sequencer
  input  logic                      tx_online_delay,
  input  logic                      rx_online_delay,
  input  logic                      tx_lock
);

  ll_reg_addr_e              reg_addr;
  logic                      access;
  logic                      addr_hit;
  logic                      wr_en;
  logic [APB_DATA_WIDTH-1:0] rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign reg_addr = ll_reg_addr_e'(paddr);
  assign access   = psel & penable;

  always_comb begin
    case (reg_addr)
      CTRL, DELAY_XZ, DELAY_YZ, DELAY_X, STATUS: addr_hit = 1'b1;
      default:                                   addr_hit = 1'b0;
    endcase
  end

  // STATUS is read only
  assign pslverr = access & (~addr_hit | (pwrite & (reg_addr == STATUS)));
  assign pready  = 1'b1;
  assign wr_en   = access & pwrite & ~pslverr;

  ////////////////////////////////////////////////////////////////////////////
  // Control and delay registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_online      <= 1'b0;
      rx_online      <= 1'b0;
      delay_xz_value <= '0;
      delay_yz_value <= '0;
      delay_x_value  <= '0;
    end else if (wr_en) begin
      case (reg_addr)
        CTRL: begin
          tx_online <= pwdata[CTRL_TX_ONLINE_BIT];
          rx_online <= pwdata[CTRL_RX_ONLINE_BIT];
        end
        DELAY_XZ: delay_xz_value <= pwdata[DELAY_WIDTH-1:0];
        DELAY_YZ: delay_yz_value <= pwdata[DELAY_WIDTH-1:0];
        DELAY_X:  delay_x_value  <= pwdata[DELAY_WIDTH-1:0];
        default:  ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (reg_addr)
      CTRL: begin
        rdata[CTRL_TX_ONLINE_BIT] = tx_online;
        rdata[CTRL_RX_ONLINE_BIT] = rx_online;
      end
      DELAY_XZ: rdata[DELAY_WIDTH-1:0] = delay_xz_value;
      DELAY_YZ: rdata[DELAY_WIDTH-1:0] = delay_yz_value;
      DELAY_X:  rdata[DELAY_WIDTH-1:0] = delay_x_value;
      STATUS: begin
        rdata[STAT_TX_ONLINE_BIT] = tx_online_delay;
        rdata[STAT_RX_ONLINE_BIT] = rx_online_delay;
        rdata[STAT_TX_LOCK_BIT]   = tx_lock;
      end
      default: rdata = '0;
    endcase
  end

  // Only driven in the access phase, unmapped reads fall out as zero
  assign prdata = access ? rdata : '0;

endmodule

`default_nettype wire

//--- src/ll_auto_sync.sv
`timescale 1ns/1ps
`default_nettype none

// Link bring-up sequencer
// TX online goes through two delay stages, RX online through one
// User marker and strobe are gated while the link comes up
module ll_auto_sync import ll_sync_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst_wr_n,

  // TX online request and its two stage delays
  input  logic                    tx_online,
  input  logic [DELAY_WIDTH-1:0]  delay_xz_value,
  input  logic [DELAY_WIDTH-1:0]  delay_yz_value,
  output logic                    tx_lock,
  output logic                    tx_online_delay,

  // User marker and strobe, raw and gated
  input  logic [MARKER_WIDTH-1:0] tx_mrk_userbit,
  input  logic                    tx_stb_userbit,
  output logic [MARKER_WIDTH-1:0] tx_auto_mrk_userbit,
  output logic                    tx_auto_stb_userbit,

  // RX online request and its delay
  input  logic                    rx_online,
  input  logic [DELAY_WIDTH-1:0]  delay_x_value,
  output logic                    rx_online_delay
);

  ////////////////////////////////////////////////////////////////////////////
  // TX stage one, word-marker lock after X+Z
  ////////////////////////////////////////////////////////////////////////////

  // Far side needs X cycles to lock onto the word marker, Z is margin
  level_delay level_delay_xz (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (tx_online),
    .delay_value (delay_xz_value),
    .delayed_en  (tx_lock)
  );

  ////////////////////////////////////////////////////////////////////////////
  // TX stage two, channel alignment after Y+Z
  ////////////////////////////////////////////////////////////////////////////

  // Starts only once the lock stage is up
  // Its output is the go for real traffic
  level_delay level_delay_yz (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (tx_lock),
    .delay_value (delay_yz_value),
    .delayed_en  (tx_online_delay)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Marker tracking after lock
  ////////////////////////////////////////////////////////////////////////////

  logic mrk_seen;
  logic first_marker;
  logic second_marker;

  // Any nonzero marker word counts as a marker
  assign mrk_seen = |tx_mrk_userbit;

  // First marker word seen since lock
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      first_marker <= 1'b0;
    end else if (!tx_lock) begin
      first_marker <= 1'b0;
    end else if (mrk_seen) begin
      first_marker <= 1'b1;
    end
  end

  // Second marker word, closes the strobe window
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      second_marker <= 1'b0;
    end else if (!first_marker) begin
      second_marker <= 1'b0;
    end else if (mrk_seen) begin
      second_marker <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // User bit gating
  ////////////////////////////////////////////////////////////////////////////

  // Markers pass until the first one after lock has gone out
  assign tx_auto_mrk_userbit = PERSISTENT_MARKER ? tx_mrk_userbit
                             : (tx_mrk_userbit & {MARKER_WIDTH{~first_marker}});

  // One strobe window between first and second marker
  // Needed by the asymmetric gearbox on the far side
  assign tx_auto_stb_userbit = PERSISTENT_STROBE ? tx_stb_userbit
                             : (tx_stb_userbit & first_marker & ~second_marker);

  ////////////////////////////////////////////////////////////////////////////
  // RX online after X
  ////////////////////////////////////////////////////////////////////////////

  level_delay level_delay_x (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (rx_online),
    .delay_value (delay_x_value),
    .delayed_en  (rx_online_delay)
  );

endmodule

`default_nettype wire

//--- src/level_delay.sv
`timescale 1ns/1ps
`default_nettype none

// Passes an enable level on after it has been held for delay_value cycles
module level_delay import ll_sync_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   rst_wr_n,
  input  logic                   enable,
  input  logic [DELAY_WIDTH-1:0] delay_value,
  output logic                   delayed_en
);

  level_delay_state_e     state;
  logic [DELAY_WIDTH-1:0] count;

  // A low enable always drops straight back to IDLE
  // Count starts at 1 on the first high sample so a zero delay lands in DONE at once
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      state <= IDLE;
      count <= '0;
    end else if (!enable) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          count <= DELAY_WIDTH'(1);
          state <= (delay_value == '0) ? DONE : COUNTING;
        end
        COUNTING: begin
          // Greater-or-equal covers a delay reprogrammed below the running count
          if (count >= delay_value) begin
            state <= DONE;
          end else begin
            count <= count + DELAY_WIDTH'(1);
          end
        end
        DONE:    state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  assign delayed_en = (state == DONE);

endmodule

`default_nettype wire

//--- src/ll_apb_pkg.sv
`default_nettype none

// APB side of the link sequencer, bus widths and register map
package ll_apb_pkg;

  localparam int unsigned APB_ADDR_WIDTH = 8;
  localparam int unsigned APB_DATA_WIDTH = 32;

  // Register byte offsets
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    CTRL     = 8'h00,
    DELAY_XZ = 8'h04,
    DELAY_YZ = 8'h08,
    DELAY_X  = 8'h0C,
    STATUS   = 8'h10
  } ll_reg_addr_e;

  // CTRL bits, the online requests
  localparam int unsigned CTRL_TX_ONLINE_BIT = 0;
  localparam int unsigned CTRL_RX_ONLINE_BIT = 1;

  // STATUS bits, read only view of the sequencer
  localparam int unsigned STAT_TX_ONLINE_BIT = 0;
  localparam int unsigned STAT_RX_ONLINE_BIT = 1;
  localparam int unsigned STAT_TX_LOCK_BIT   = 2;

endpackage

`default_nettype wire

//--- src/ll_sync_pkg.sv
`default_nettype none

// Link side constants shared by the sequencer and its delay counters
package ll_sync_pkg;

  // Width of the user marker field on the TX side
  localparam int unsigned MARKER_WIDTH = 4;

  // Width of every programmable delay count
  localparam int unsigned DELAY_WIDTH = 8;

  // Zero keeps the one-shot gating in place
  localparam logic PERSISTENT_MARKER = 1'b0;
  localparam logic PERSISTENT_STROBE = 1'b0;

  // Delay counter states
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    COUNTING = 2'd1,
    DONE     = 2'd2
  } level_delay_state_e;

endpackage

`default_nettype wire
